/* design/mem_test_pkg.sv */
package mem_test_pkg;

    // Bank geometry
    localparam int addr_width     = 8;
    localparam int depth          = 256;
    localparam int data_width     = 32;
    localparam int num_banks      = 4;
    localparam int bank_idx_width = 2;

    localparam logic [addr_width-1:0] max_addr = addr_width'(depth - 1);

    // Galois LFSR with taps from the usual 32-bit table
    localparam logic [data_width-1:0] lfsr_poly      = 32'h8000_0803;
    localparam logic [data_width-1:0] lfsr_seed_init = 32'h0000_0001;

    // Report frame codes
    localparam logic [7:0] frame_pass  = 8'h50;
    localparam logic [7:0] frame_error = 8'h45;

    localparam int byte_idx_width = 4;
    localparam logic [byte_idx_width-1:0] frame_pass_last  = 4'd1;
    localparam logic [byte_idx_width-1:0] frame_error_last = 4'd12;

    typedef struct packed {
        logic                  valid;
        logic                  is_read;
        logic                  last;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } test_op_t;

    typedef struct packed {
        logic                  done;
        logic                  error;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] expected;
        logic [data_width-1:0] actual;
    } bank_result_t;

    typedef struct packed {
        logic                      enable;
        logic [bank_idx_width-1:0] bank;
        logic [addr_width-1:0]     addr;
        logic [data_width-1:0]     mask;
    } inject_t;

endpackage

/* design/dual_port_ram.sv */
`timescale 1ns/100ps

module dual_port_ram #(
    parameter int addr_w = mem_test_pkg::addr_width,
    parameter int data_w = mem_test_pkg::data_width
) (
    input  logic              clk,
    // Write port
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [data_w-1:0] wr_data,
    // Read port
    input  logic              rd_en,
    input  logic [addr_w-1:0] rd_addr,
    output logic [data_w-1:0] rd_data
);

    (* ram_style = "block" *) logic [data_w-1:0] mem [2**addr_w];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read returns old data on a same-address collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* design/test_sequencer.sv */
`timescale 1ns/100ps

module test_sequencer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic                   report_busy,
    output mem_test_pkg::test_op_t op,
    output logic                   busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_read,
        st_drain,
        st_report
    } state_t;

    state_t                              state;
    logic [mem_test_pkg::addr_width-1:0] addr_cnt;
    logic [mem_test_pkg::data_width-1:0] lfsr;
    logic [mem_test_pkg::data_width-1:0] seed;
    logic                                last_addr;

    function automatic logic [mem_test_pkg::data_width-1:0] lfsr_step(
        input logic [mem_test_pkg::data_width-1:0] s
    );
        logic [mem_test_pkg::data_width-1:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ mem_test_pkg::lfsr_poly;
        end
        return n;
    endfunction

    assign last_addr = (addr_cnt == mem_test_pkg::max_addr);
    assign busy      = (state != st_idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            addr_cnt <= '0;
            lfsr     <= '0;
            seed     <= mem_test_pkg::lfsr_seed_init;
            op       <= '0;
        end else begin
            op <= '0;
            case (state)
                st_idle: begin
                    // addr_cnt sits at zero here after the read phase wraps
                    if (start && !report_busy) begin
                        op.valid <= 1'b1;
                        op.addr  <= addr_cnt;
                        op.data  <= seed;
                        lfsr     <= lfsr_step(seed);
                        addr_cnt <= addr_cnt + 1'b1;
                        state    <= st_write;
                    end
                end
                st_write: begin
                    op.valid <= 1'b1;
                    op.addr  <= addr_cnt;
                    op.data  <= lfsr;
                    lfsr     <= lfsr_step(lfsr);
                    addr_cnt <= addr_cnt + 1'b1;
                    if (last_addr) begin
                        // Replay from this pass seed, keep the next one
                        lfsr  <= seed;
                        seed  <= lfsr_step(lfsr);
                        state <= st_read;
                    end
                end
                st_read: begin
                    op.valid   <= 1'b1;
                    op.is_read <= 1'b1;
                    op.last    <= last_addr;
                    op.addr    <= addr_cnt;
                    op.data    <= lfsr;
                    lfsr       <= lfsr_step(lfsr);
                    addr_cnt   <= addr_cnt + 1'b1;
                    if (last_addr) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    // Wait for the reporter to pick up the results
                    if (report_busy) begin
                        state <= st_report;
                    end
                end
                st_report: begin
                    if (!report_busy) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* design/bank_tester.sv */
`timescale 1ns/100ps

module bank_tester #(
    parameter int bank_index = 0
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  mem_test_pkg::test_op_t     op,
    input  mem_test_pkg::inject_t      inject,
    output mem_test_pkg::bank_result_t result
);

    logic                                wr_en;
    logic                                rd_en;
    logic                                inject_hit;
    logic [mem_test_pkg::data_width-1:0] wr_data;
    logic [mem_test_pkg::data_width-1:0] rd_data;

    // Read stage alongside the RAM
    logic                                rd_valid_q;
    logic                                last_q;
    logic [mem_test_pkg::addr_width-1:0] addr_q;
    logic [mem_test_pkg::data_width-1:0] expected_q;

    // Compare stage
    logic                                done_q;
    logic                                error_q;
    logic [mem_test_pkg::addr_width-1:0] res_addr;
    logic [mem_test_pkg::data_width-1:0] res_expected;
    logic [mem_test_pkg::data_width-1:0] res_actual;

    assign wr_en = op.valid && !op.is_read;
    assign rd_en = op.valid && op.is_read;

    assign inject_hit = inject.enable
                     && (inject.bank == bank_index[mem_test_pkg::bank_idx_width-1:0])
                     && (inject.addr == op.addr);

    // Corrupt the stored word only, the expected value stays clean
    assign wr_data = inject_hit ? (op.data ^ inject.mask) : op.data;

    dual_port_ram ram0 (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (op.addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (op.addr),
        .rd_data (rd_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid_q <= 1'b0;
            last_q     <= 1'b0;
            done_q     <= 1'b0;
            error_q    <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;
            last_q     <= rd_en && op.last;
            done_q     <= last_q;
            error_q    <= rd_valid_q && (rd_data != expected_q);
        end
    end

    always_ff @(posedge clk) begin
        addr_q       <= op.addr;
        expected_q   <= op.data;
        res_addr     <= addr_q;
        res_expected <= expected_q;
        res_actual   <= rd_data;
    end

    assign result = '{
        done:     done_q,
        error:    error_q,
        addr:     res_addr,
        expected: res_expected,
        actual:   res_actual
    };

endmodule

/* design/error_reporter.sv */
`timescale 1ns/100ps

module error_reporter (
    input  logic                       clk,
    input  logic                       arst_n,
    input  mem_test_pkg::bank_result_t results [mem_test_pkg::num_banks],
    output logic [7:0]                 tx_data,
    output logic                       tx_data_ready,
    input  logic                       tx_data_accepted,
    output logic                       report_busy
);

    // First error of the pass
    logic                                    have_err;
    logic [mem_test_pkg::bank_idx_width-1:0] err_bank;
    logic [mem_test_pkg::addr_width-1:0]     err_addr;
    logic [mem_test_pkg::data_width-1:0]     err_expected;
    logic [mem_test_pkg::data_width-1:0]     err_actual;
    logic [7:0]                              err_cnt;
    logic [7:0]                              pass_cnt;

    // Frame output
    logic                                    sending;
    logic [mem_test_pkg::byte_idx_width-1:0] byte_idx;
    logic                                    last_byte;

    logic                                    any_err;
    logic [mem_test_pkg::bank_idx_width-1:0] first_bank;
    logic [7:0]                              cycle_errs;
    logic [8:0]                              cnt_sum;

    // Lowest bank wins, so scan downward and let the last hit stand
    always_comb begin
        any_err    = 1'b0;
        first_bank = '0;
        cycle_errs = '0;
        for (int i = mem_test_pkg::num_banks - 1; i >= 0; i--) begin
            if (results[i].error) begin
                any_err    = 1'b1;
                first_bank = i[mem_test_pkg::bank_idx_width-1:0];
                cycle_errs = cycle_errs + 8'd1;
            end
        end
    end

    assign cnt_sum = {1'b0, err_cnt} + {1'b0, cycle_errs};

    assign last_byte = have_err ? (byte_idx == mem_test_pkg::frame_error_last)
                                : (byte_idx == mem_test_pkg::frame_pass_last);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            have_err <= 1'b0;
            err_cnt  <= '0;
        end else if (sending && tx_data_accepted && last_byte) begin
            have_err <= 1'b0;
            err_cnt  <= '0;
        end else if (any_err) begin
            have_err <= 1'b1;
            err_cnt  <= cnt_sum[8] ? 8'hff : cnt_sum[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (any_err && !have_err) begin
            err_bank     <= first_bank;
            err_addr     <= results[first_bank].addr;
            err_expected <= results[first_bank].expected;
            err_actual   <= results[first_bank].actual;
        end
    end

    // Bank 0 done marks the end of a pass
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sending  <= 1'b0;
            byte_idx <= '0;
            pass_cnt <= '0;
        end else if (results[0].done) begin
            pass_cnt <= pass_cnt + 8'd1;
            sending  <= 1'b1;
            byte_idx <= '0;
        end else if (sending && tx_data_accepted) begin
            if (last_byte) begin
                sending <= 1'b0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    always_comb begin
        tx_data = pass_cnt;
        if (!have_err) begin
            if (byte_idx == '0) begin
                tx_data = mem_test_pkg::frame_pass;
            end
        end else begin
            case (byte_idx)
                4'd0:    tx_data = mem_test_pkg::frame_error;
                4'd1:    tx_data = 8'(err_bank);
                4'd2:    tx_data = err_addr;
                4'd3:    tx_data = err_expected[31:24];
                4'd4:    tx_data = err_expected[23:16];
                4'd5:    tx_data = err_expected[15:8];
                4'd6:    tx_data = err_expected[7:0];
                4'd7:    tx_data = err_actual[31:24];
                4'd8:    tx_data = err_actual[23:16];
                4'd9:    tx_data = err_actual[15:8];
                4'd10:   tx_data = err_actual[7:0];
                4'd11:   tx_data = err_cnt;
                default: tx_data = pass_cnt;
            endcase
        end
    end

    assign tx_data_ready = sending;
    assign report_busy   = sending;

endmodule

/* design/mem_test_top.sv */
`timescale 1ns/100ps

module mem_test_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  mem_test_pkg::inject_t inject,
    output logic [7:0]            tx_data,
    output logic                  tx_data_ready,
    input  logic                  tx_data_accepted,
    output logic                  busy
);

    mem_test_pkg::test_op_t     op;
    mem_test_pkg::bank_result_t results [mem_test_pkg::num_banks];
    logic                       report_busy;

    test_sequencer seq0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .report_busy (report_busy),
        .op          (op),
        .busy        (busy)
    );

    // Every bank sees the same operation stream
    for (genvar i = 0; i < mem_test_pkg::num_banks; i++) begin : g_bank
        bank_tester #(
            .bank_index (i)
        ) tester (
            .clk    (clk),
            .arst_n (arst_n),
            .op     (op),
            .inject (inject),
            .result (results[i])
        );
    end

    error_reporter rep0 (
        .clk              (clk),
        .arst_n           (arst_n),
        .results          (results),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted),
        .report_busy      (report_busy)
    );

endmodule

/* tb/mem_test_checker.sv */
`timescale 1ns/100ps

module mem_test_checker #(
    parameter bit tx_side = 1'b1
) (
    input logic       clk,
    input logic       arst_n,
    input logic       start,
    input logic       busy,
    input logic [7:0] tx_data,
    input logic       tx_data_ready,
    input logic       tx_data_accepted
);

    if (tx_side) begin : g_tx
        // A byte on offer holds until it is taken
        a_tx_hold: assert property (@(posedge clk) disable iff (!arst_n)
            tx_data_ready && !tx_data_accepted |=> tx_data_ready && $stable(tx_data))
            else $error("tx_data changed or tx_data_ready fell before an accept");

        a_reset_quiet: assert property (@(posedge clk) $rose(arst_n) |-> !tx_data_ready)
            else $error("tx_data_ready high in the cycle after reset release");
    end else begin : g_busy
        a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
            start && !busy && !tx_data_ready |=> busy)
            else $error("busy did not rise after a start while idle");

        // Only the end of a report frame may end a pass
        a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
            $fell(busy) |-> $past(tx_data_ready, 2) && !$past(tx_data_ready))
            else $error("busy fell without a finished report frame");
    end

endmodule

bind error_reporter mem_test_checker #(.tx_side(1'b1)) chk_tx (
    .clk              (clk),
    .arst_n           (arst_n),
    .start            (1'b0),
    .busy             (report_busy),
    .tx_data          (tx_data),
    .tx_data_ready    (tx_data_ready),
    .tx_data_accepted (tx_data_accepted)
);

// Inside the sequencer the reporter busy level equals tx_data_ready
bind test_sequencer mem_test_checker #(.tx_side(1'b0)) chk_seq (
    .clk              (clk),
    .arst_n           (arst_n),
    .start            (start),
    .busy             (busy),
    .tx_data          (8'h00),
    .tx_data_ready    (report_busy),
    .tx_data_accepted (1'b0)
);

/* tb/mem_test_tb.sv */
`timescale 1ns/100ps

module mem_test_tb;

    localparam int timeout_cycles = 2000;

    logic                  clk;
    logic                  arst_n;
    logic                  start;
    mem_test_pkg::inject_t inject;
    logic [7:0]            tx_data;
    logic                  tx_data_ready;
    logic                  tx_data_accepted;
    logic                  busy;

    integer      rand_seed = 47244;
    int          frames_seen = 0;
    int          frames_checked = 0;
    int          checks = 0;
    int          failures = 0;
    int          test_failures = 0;
    int          tests = 0;
    string       test_name = "reset";
    logic [7:0]  rx_frame [$];
    logic [7:0]  exp_frame [$];
    logic [31:0] model_seed;
    logic [7:0]  model_pass;

    mem_test_top dut0 (
        .clk              (clk),
        .arst_n           (arst_n),
        .start            (start),
        .inject           (inject),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted),
        .busy             (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = {1'b0, s[31:1]};
        if (s[0]) begin
            n = n ^ mem_test_pkg::lfsr_poly;
        end
        return n;
    endfunction

    function automatic mem_test_pkg::inject_t fault(input logic [1:0] bank,
                                                    input logic [7:0] addr,
                                                    input logic [31:0] mask);
        return '{enable: 1'b1, bank: bank, addr: addr, mask: mask};
    endfunction

    // Expected report frame of one pass
    function automatic void build_frame(input logic [31:0] pass_seed,
                                        input mem_test_pkg::inject_t inj,
                                        input logic [7:0] pass_num);
        logic [31:0] word;
        logic [31:0] bad;
        word = pass_seed;
        exp_frame.delete();
        if (inj.enable && inj.mask != '0) begin
            for (int a = 0; a < int'(inj.addr); a++) begin
                word = lfsr_next(word);
            end
            bad = word ^ inj.mask;
            exp_frame.push_back(mem_test_pkg::frame_error);
            exp_frame.push_back(8'(inj.bank));
            exp_frame.push_back(inj.addr);
            for (int i = 3; i >= 0; i--) begin
                exp_frame.push_back(word[i*8 +: 8]);
            end
            for (int i = 3; i >= 0; i--) begin
                exp_frame.push_back(bad[i*8 +: 8]);
            end
            exp_frame.push_back(8'd1);
        end else begin
            exp_frame.push_back(mem_test_pkg::frame_pass);
        end
        exp_frame.push_back(pass_num);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (frames_checked < target || busy) begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) begin
                abort_run($sformatf("%s: no report frame or busy stuck high", test_name));
            end
        end
    endtask

    // One full pass with an optional second start during the read phase
    task automatic run_pass(input mem_test_pkg::inject_t inj, input bit poke_busy);
        int target;
        target = frames_checked + 1;
        model_pass = model_pass + 8'd1;
        build_frame(model_seed, inj, model_pass);
        repeat (256) model_seed = lfsr_next(model_seed);
        inject = inj;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (poke_busy) begin
            repeat (300) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        wait_done(target);
        inject = '0;
        @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_failures = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("%-20s %s", test_name, (test_failures == 0) ? "ok" : "failed");
    endtask

    // Accept each byte after a random delay of 0 to 3 cycles
    initial begin : sink
        int delay;
        tx_data_accepted = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_data_ready) begin
                delay = $unsigned($random(rand_seed)) % 4;
                repeat (delay) @(negedge clk);
                rx_frame.push_back(tx_data);
                tx_data_accepted = 1'b1;
                @(negedge clk);
                tx_data_accepted = 1'b0;
                if (!tx_data_ready) begin
                    frames_seen++;
                end
            end
        end
    end

    initial begin : compare
        forever begin
            @(posedge clk);
            if (frames_seen > frames_checked) begin
                checks++;
                if (rx_frame.size() != exp_frame.size()) begin
                    $display("CHECK FAILED %s: frame length expected %0d actual %0d",
                             test_name, exp_frame.size(), rx_frame.size());
                    failures++;
                    test_failures++;
                end else begin
                    foreach (exp_frame[i]) begin
                        if (rx_frame[i] !== exp_frame[i]) begin
                            $display("CHECK FAILED %s: byte %0d expected %02h actual %02h",
                                     test_name, i, exp_frame[i], rx_frame[i]);
                            failures++;
                            test_failures++;
                        end
                    end
                end
                rx_frame.delete();
                frames_checked++;
            end
        end
    end

    initial begin : stimulus
        arst_n = 1'b0;
        start = 1'b0;
        inject = '0;
        model_seed = mem_test_pkg::lfsr_seed_init;
        model_pass = 8'd0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        checks++;
        if (busy || tx_data_ready) begin
            $display("CHECK FAILED %s: busy tx_data_ready expected 0 0 actual %b %b",
                     test_name, busy, tx_data_ready);
            failures++;
        end

        begin_test("clean_after_reset");
        run_pass('0, 1'b0);
        end_test();

        begin_test("seed_chain");
        repeat (3) run_pass('0, 1'b0);
        run_pass(fault(2'd2, 8'd200, 32'h0000_0100), 1'b0);
        end_test();

        begin_test("single_bit_fault");
        run_pass(fault(2'd1, 8'd17, 32'h0008_0000), 1'b0);
        end_test();

        begin_test("two_bank_faults");
        run_pass(fault(2'd0, 8'd99, 32'h8000_0001), 1'b0);
        run_pass(fault(2'd3, 8'd255, 32'h00ff_0000), 1'b0);
        run_pass(fault(2'd3, 8'd0, 32'hffff_ffff), 1'b0);
        end_test();

        begin_test("back_pressure");
        run_pass(fault(2'd2, 8'd128, 32'h5a5a_a5a5), 1'b0);
        run_pass('0, 1'b0);
        end_test();

        begin_test("start_while_busy");
        run_pass('0, 1'b1);
        run_pass(fault(2'd1, 8'd3, 32'h0000_0001), 1'b0);
        end_test();

        $display("tests %0d, checks %0d, failures %0d", tests, checks, failures);
        if (failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
design/mem_test_pkg.sv
design/dual_port_ram.sv
design/test_sequencer.sv
design/bank_tester.sv
design/error_reporter.sv
design/mem_test_top.sv
tb/mem_test_checker.sv
tb/mem_test_tb.sv

/* run.sh */
#!/bin/sh
# Build the memory self-test with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module mem_test_tb -f list.f \
    && ./obj_dir/Vmem_test_tb | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
